/* src.f */
+incdir+logic
logic/alpha_pkg.sv
logic/alpha_bias_regs.sv
logic/alpha_front_panel.sv
logic/alpha_serial_loader.sv
logic/alpha_control.sv
logic/alpha_test_top.sv
tests/alpha_test_checker.sv
tests/alpha_test_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module alpha_test_tb -f src.f -o alpha_sim \
	&& ./obj_dir/alpha_sim +verilator+error+limit+100 | tee /dev/stderr | grep -q "Everything OK" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* tests/alpha_test_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "alpha_cfg.svh"

module alpha_test_tb;

	localparam logic [3:0] CHIP_BASE = 4'h8;

	logic        clock;
	logic        reset;
	logic        button;
	logic [3:0]  rot;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [3:0]  coax_led;
	logic        dreset;
	logic        sync;
	logic        tok_a_in;
	logic        trig_top;
	logic        sin;
	logic        sclk;
	logic        pclk;
	logic        busy;
	logic [2:0]  done_flags;

	logic [11:0] bias_model [4];
	logic [31:0] lcg_state = 32'h759b;
	logic [15:0] captured [$];
	logic [15:0] shift_word;
	int          bit_count;
	logic        sclk_q;
	int          stable_cnt;
	logic [3:0]  rot_prev;

	alpha_test_top u_dut (
		.clock      (clock),
		.reset      (reset),
		.button     (button),
		.rot        (rot),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.coax_led   (coax_led),
		.dreset     (dreset),
		.sync       (sync),
		.tok_a_in   (tok_a_in),
		.trig_top   (trig_top),
		.sin        (sin),
		.sclk       (sclk),
		.pclk       (pclk),
		.busy       (busy),
		.done_flags (done_flags)
	);

	bind alpha_test_top alpha_test_checker u_checker (
		.clock    (clock),
		.reset    (reset),
		.dreset   (dreset),
		.sync     (sync),
		.sin      (sin),
		.sclk     (sclk),
		.pclk     (pclk),
		.tok_a_in (tok_a_in),
		.trig_top (trig_top)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		$display("Something failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic expect_value(input string test, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act == exp) else begin
			$display("Mismatch %s expected 0x%08h actual 0x%08h", test, exp, act);
			abort_run("value check failed");
		end
	endtask

	task automatic apb_access(input logic write, input logic [3:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		@(posedge clock);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clock);
		penable <= 1'b1;
		n = 0;
		do begin
			@(posedge clock);
			n++;
			if (n > 16) abort_run("APB transfer never saw pready");
		end while (!pready);
		rdata = prdata;
		expect_value("apb_pslverr", 32'd0, {31'd0, pslverr});
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_bias(input logic [1:0] idx, input logic [31:0] value);
		logic [31:0] ignored;
		apb_access(1'b1, {idx, 2'b00}, value, ignored);
		bias_model[idx] = value[11:0];
	endtask

	task automatic check_bias(input logic [1:0] idx, input string test);
		logic [31:0] rd;
		apb_access(1'b0, {idx, 2'b00}, 32'd0, rd);
		expect_value(test, {20'd0, bias_model[idx]}, rd);
	endtask

	// switch is active low, release starts the sequence
	task automatic press_button(input logic [3:0] position);
		@(posedge clock);
		rot <= ~position;
		repeat (4) @(posedge clock);
		button <= 1'b1;
		repeat (3) @(posedge clock);
		button <= 1'b0;
	endtask

	// serial capture, one bit per rising sclk, word closed by pclk
	always @(posedge clock) begin
		if (reset) begin
			sclk_q     <= 1'b0;
			shift_word <= 16'd0;
			bit_count  <= 0;
		end else begin
			sclk_q <= sclk;
			if (sclk && !sclk_q) begin
				shift_word <= {shift_word[14:0], sin};
				bit_count  <= bit_count + 1;
			end
			if (pclk) begin
				expect_value("bits_per_word", 32'd16, 32'(bit_count));
				captured.push_back(shift_word);
				bit_count <= 0;
			end
		end
	end

	// leds follow the inverted switch once it has settled
	always @(posedge clock) begin
		if (reset) begin
			stable_cnt = 0;
			rot_prev   = rot;
		end else begin
			if (rot != rot_prev) begin
				stable_cnt = 0;
			end else if (stable_cnt < 3) begin
				stable_cnt = stable_cnt + 1;
			end
			rot_prev = rot;
			if (stable_cnt >= 3) begin
				expect_value("coax_led", {28'd0, ~rot}, {28'd0, coax_led});
			end
		end
	end

	always @(posedge clock) begin
		if (u_dut.u_checker.failed) abort_run("a protocol assertion fired");
	end

	initial begin
		int          n;
		logic [15:0] expected;
		reset   = 1'b1;
		button  = 1'b0;
		rot     = 4'hf;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 4'd0;
		pwdata  = 32'd0;
		for (int i = 0; i < 4; i++) bias_model[i] = `ALPHA_BIAS_RESET;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		expect_value("reset_outputs", 32'd0, 32'({dreset, sync, tok_a_in, trig_top, sin,
			sclk, pclk, busy, done_flags}));

		// register reset values and readback
		for (int i = 0; i < 4; i++) check_bias(2'(i), $sformatf("reset_value_reg%0d", i));
		for (int i = 0; i < 4; i++) write_bias(2'(i), lcg_next());
		for (int i = 0; i < 4; i++) check_bias(2'(i), $sformatf("readback_reg%0d", i));

		// sequence 1, dreset then sync
		press_button(4'd1);
		n = 0;
		do begin
			@(posedge clock);
			n++;
			if (n > 100) abort_run("dreset never rose after a sequence 1 start");
		end while (!dreset);
		n = 0;
		do begin
			@(posedge clock);
			n++;
			if (n > 100) abort_run("dreset stuck high");
		end while (dreset);
		expect_value("seq1_dreset_length", 32'(`ALPHA_DRESET_CYCLES), 32'(n));
		expect_value("seq1_sync", 32'd1, 32'(sync));
		@(posedge clock);
		expect_value("seq1_sync_width", 32'd0, 32'(sync));
		expect_value("seq1_done_flags", 32'd1, 32'(done_flags));

		// sequence 2, with a dropped press and a late write to db_bias
		captured.delete();
		for (int i = 0; i < 4; i++) write_bias(2'(i), lcg_next());
		press_button(4'd2);
		n = 0;
		do begin
			@(posedge clock);
			n++;
			if (n > 100) abort_run("busy never rose after a sequence 2 start");
		end while (!busy);
		press_button(4'd2);
		write_bias(2'd3, lcg_next());
		n = 0;
		do begin
			@(posedge clock);
			n++;
			if (n > 2000) abort_run("sequence 2 never finished");
		end while (busy);
		expect_value("seq2_done_flags", 32'd3, 32'(done_flags));
		expect_value("seq2_word_count", 32'd4, 32'(captured.size()));
		for (int i = 0; i < 4; i++) begin
			expected = {CHIP_BASE + 4'(i), bias_model[2'(i)]};
			expect_value($sformatf("seq2_word%0d", i), 32'(expected), 32'(captured[i]));
		end

		// sequence 3, token then trigger
		press_button(4'd3);
		n = 0;
		do begin
			@(posedge clock);
			n++;
			if (n > 100) abort_run("tok_a_in never rose after a sequence 3 start");
		end while (!tok_a_in);
		@(posedge clock);
		expect_value("seq3_trig_top", 32'd1, 32'(trig_top));
		expect_value("seq3_token_width", 32'd0, 32'(tok_a_in));
		@(posedge clock);
		expect_value("seq3_trig_width", 32'd0, 32'(trig_top));
		expect_value("seq3_done_flags", 32'd7, 32'(done_flags));

		// positions without a sequence stay quiet
		for (int k = 0; k < 2; k++) begin
			press_button((k == 0) ? 4'd0 : 4'd5);
			for (int c = 0; c < 40; c++) begin
				@(posedge clock);
				expect_value("idle_position_activity", 32'd0,
					32'(dreset | sclk | tok_a_in | busy));
			end
		end
		expect_value("no_extra_words", 32'd4, 32'(captured.size()));

		@(posedge clock);
		if (u_dut.u_checker.failed) begin
			abort_run("a protocol assertion fired");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tests/alpha_test_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "alpha_cfg.svh"

module alpha_test_checker (
	input wire logic clock,
	input wire logic reset,
	input wire logic dreset,
	input wire logic sync,
	input wire logic sin,
	input wire logic sclk,
	input wire logic pclk,
	input wire logic tok_a_in,
	input wire logic trig_top
);

	int   dreset_len;
	logic len_err = 1'b0;
	logic excl_err = 1'b0;
	logic sin_err = 1'b0;
	logic pclk_err = 1'b0;
	logic trig_err = 1'b0;
	logic failed;

	// cycles the current dreset pulse has lasted
	always_ff @(posedge clock) begin
		if (reset) begin
			dreset_len <= 0;
		end else if (dreset) begin
			dreset_len <= dreset_len + 1;
		end else begin
			dreset_len <= 0;
		end
	end

	dreset_length: assert property (@(posedge clock) disable iff (reset)
		$fell(dreset) |-> (dreset_len == `ALPHA_DRESET_CYCLES))
	else begin
		len_err = 1'b1;
		$error("dreset pulse has the wrong length");
	end

	dreset_sync_excl: assert property (@(posedge clock) disable iff (reset)
		!(dreset && sync))
	else begin
		excl_err = 1'b1;
		$error("dreset and sync high together");
	end

	// chip samples sin on the rising sclk edge
	sin_stable: assert property (@(posedge clock) disable iff (reset)
		sclk |-> $stable(sin))
	else begin
		sin_err = 1'b1;
		$error("sin changed while sclk was high");
	end

	pclk_sclk_low: assert property (@(posedge clock) disable iff (reset)
		pclk |-> !sclk)
	else begin
		pclk_err = 1'b1;
		$error("pclk high while sclk was high");
	end

	trig_after_tok: assert property (@(posedge clock) disable iff (reset)
		tok_a_in |=> (trig_top && !tok_a_in))
	else begin
		trig_err = 1'b1;
		$error("trig_top did not follow tok_a_in by one cycle");
	end

	assign failed = len_err | excl_err | sin_err | pclk_err | trig_err;

endmodule

`default_nettype wire

/* logic/alpha_test_top.sv */
`timescale 1ns/10ps
`default_nettype none

module alpha_test_top (
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic        button,
	input  wire logic [3:0]  rot,
	input  wire logic        psel,
	input  wire logic        penable,
	input  wire logic        pwrite,
	input  wire logic [3:0]  paddr,
	input  wire logic [31:0] pwdata,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             pslverr,
	output logic [3:0]       coax_led,
	output logic             dreset,
	output logic             sync,
	output logic             tok_a_in,
	output logic             trig_top,
	output logic             sin,
	output logic             sclk,
	output logic             pclk,
	output logic             busy,
	output logic [2:0]       done_flags
);

	logic [11:0]          cmp_bias;
	logic [11:0]          isel;
	logic [11:0]          sb_bias;
	logic [11:0]          db_bias;
	alpha_pkg::sequence_t start;

	alpha_bias_regs u_bias_regs (
		.clock    (clock),
		.reset    (reset),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.cmp_bias (cmp_bias),
		.isel     (isel),
		.sb_bias  (sb_bias),
		.db_bias  (db_bias)
	);

	// synchronized rotary level drives the coax leds
	alpha_front_panel u_front_panel (
		.clock     (clock),
		.reset     (reset),
		.button    (button),
		.rot       (rot),
		.rot_level (coax_led),
		.start     (start)
	);

	alpha_control u_control (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.cmp_bias   (cmp_bias),
		.isel       (isel),
		.sb_bias    (sb_bias),
		.db_bias    (db_bias),
		.dreset     (dreset),
		.sync       (sync),
		.tok_a_in   (tok_a_in),
		.trig_top   (trig_top),
		.sin        (sin),
		.sclk       (sclk),
		.pclk       (pclk),
		.busy       (busy),
		.done_flags (done_flags)
	);

endmodule

`default_nettype wire

/* logic/alpha_control.sv */
`timescale 1ns/10ps
`default_nettype none

`include "alpha_cfg.svh"

module alpha_control (
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire alpha_pkg::sequence_t start,
	input  wire logic [11:0] cmp_bias,
	input  wire logic [11:0] isel,
	input  wire logic [11:0] sb_bias,
	input  wire logic [11:0] db_bias,
	output logic             dreset,
	output logic             sync,
	output logic             tok_a_in,
	output logic             trig_top,
	output logic             sin,
	output logic             sclk,
	output logic             pclk,
	output logic             busy,
	output logic [2:0]       done_flags
);

	localparam int DRESET_N = `ALPHA_DRESET_CYCLES;
	localparam int DCNT_W   = (DRESET_N > 1) ? $clog2(DRESET_N) : 1;

	localparam logic [DCNT_W-1:0] DCNT_LAST = DCNT_W'(DRESET_N - 1);

	typedef enum logic [2:0] {
		st_idle,
		st_dreset,
		st_sync,
		st_load,
		st_wait,
		st_token,
		st_trig
	} ctl_state_t;

	ctl_state_t              state;
	logic [DCNT_W-1:0]       dcnt;
	alpha_pkg::bias_addr_t   word_idx;
	alpha_pkg::serial_word_t ld_word;
	logic                    ld_load;
	logic                    ld_done;

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= st_idle;
			dcnt       <= '0;
			word_idx   <= alpha_pkg::cmp_bias;
			done_flags <= 3'b000;
		end else begin
			case (state)
				// starts are only taken here
				st_idle: begin
					dcnt <= '0;
					if (start[alpha_pkg::SEQ_RESET_BIT]) begin
						state <= st_dreset;
					end else if (start[alpha_pkg::SEQ_LOAD_BIT]) begin
						state    <= st_load;
						word_idx <= alpha_pkg::cmp_bias;
					end else if (start[alpha_pkg::SEQ_TOKEN_BIT]) begin
						state <= st_token;
					end
				end
				st_dreset: begin
					if (dcnt == DCNT_LAST) begin
						state <= st_sync;
					end else begin
						dcnt <= dcnt + 1'b1;
					end
				end
				st_sync: begin
					state         <= st_idle;
					done_flags[0] <= 1'b1;
				end
				st_load: state <= st_wait;
				st_wait: begin
					if (ld_done) begin
						if (word_idx == alpha_pkg::db_bias) begin
							state         <= st_idle;
							done_flags[1] <= 1'b1;
						end else begin
							state    <= st_load;
							word_idx <= alpha_pkg::bias_addr_t'(word_idx + 2'd1);
						end
					end
				end
				st_token: state <= st_trig;
				st_trig: begin
					state         <= st_idle;
					done_flags[2] <= 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// current bias value, sampled by the loader at the load cycle
	always_comb begin
		ld_word.addr = alpha_pkg::CHIP_ADDR_BASE + {2'b00, word_idx};
		case (word_idx)
			alpha_pkg::cmp_bias: ld_word.value = cmp_bias;
			alpha_pkg::isel:     ld_word.value = isel;
			alpha_pkg::sb_bias:  ld_word.value = sb_bias;
			alpha_pkg::db_bias:  ld_word.value = db_bias;
			default:             ld_word.value = 12'd0;
		endcase
	end

	assign ld_load  = (state == st_load);
	assign dreset   = (state == st_dreset);
	assign sync     = (state == st_sync);
	assign tok_a_in = (state == st_token);
	assign trig_top = (state == st_trig);
	assign busy     = (state != st_idle);

	alpha_serial_loader u_loader (
		.clock (clock),
		.reset (reset),
		.load  (ld_load),
		.word  (ld_word),
		.done  (ld_done),
		.sin   (sin),
		.sclk  (sclk),
		.pclk  (pclk)
	);

endmodule

`default_nettype wire

/* logic/alpha_serial_loader.sv */
`timescale 1ns/10ps
`default_nettype none

`include "alpha_cfg.svh"

module alpha_serial_loader (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic load,
	input  wire alpha_pkg::serial_word_t word,
	output logic      done,
	output logic      sin,
	output logic      sclk,
	output logic      pclk
);

	localparam int HALF    = `ALPHA_SCLK_HALF;
	localparam int PHASE_W = (2 * HALF > 1) ? $clog2(2 * HALF) : 1;

	localparam logic [PHASE_W-1:0] PHASE_HIGH = PHASE_W'(HALF);
	localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(2 * HALF - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_shift,
		st_latch,
		st_done
	} ld_state_t;

	ld_state_t    state;
	logic [15:0]  shreg;
	logic [3:0]   bit_cnt;
	logic [PHASE_W-1:0] phase_cnt;

	// control path
	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= st_idle;
			bit_cnt   <= 4'd0;
			phase_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (load) begin
						state     <= st_shift;
						bit_cnt   <= 4'd0;
						phase_cnt <= '0;
					end
				end
				st_shift: begin
					if (phase_cnt == PHASE_LAST) begin
						phase_cnt <= '0;
						if (bit_cnt == 4'd15) begin
							state <= st_latch;
						end else begin
							bit_cnt <= bit_cnt + 4'd1;
						end
					end else begin
						phase_cnt <= phase_cnt + 1'b1;
					end
				end
				st_latch: state <= st_done;
				st_done:  state <= st_idle;
				default:  state <= st_idle;
			endcase
		end
	end

	// payload, word only taken while idle
	always_ff @(posedge clock) begin
		if (state == st_idle && load) begin
			shreg <= word;
		end else if (state == st_shift && phase_cnt == PHASE_LAST) begin
			shreg <= {shreg[14:0], 1'b0};
		end
	end

	// sclk high in the second half of each bit
	assign sin  = (state == st_shift) && shreg[15];
	assign sclk = (state == st_shift) && (phase_cnt >= PHASE_HIGH);
	assign pclk = (state == st_latch);
	assign done = (state == st_done);

endmodule

`default_nettype wire

/* logic/alpha_front_panel.sv */
`timescale 1ns/10ps
`default_nettype none

`include "alpha_cfg.svh"

module alpha_front_panel (
	input  wire logic       clock,
	input  wire logic       reset,
	input  wire logic       button,
	input  wire logic [3:0] rot,
	output logic [3:0]      rot_level,
	output alpha_pkg::sequence_t start
);

	localparam int DEPTH = `ALPHA_BUTTON_DEPTH;

	logic [3:0]       rot_meta;
	logic [DEPTH-1:0] button_pipe;
	logic             released;

	// switch is active low, invert on the way in
	always_ff @(posedge clock) begin
		if (reset) begin
			rot_meta  <= 4'd0;
			rot_level <= 4'd0;
		end else begin
			rot_meta  <= ~rot;
			rot_level <= rot_meta;
		end
	end

	// button delay line, newest sample in bit 0
	always_ff @(posedge clock) begin
		if (reset) begin
			button_pipe <= '0;
		end else begin
			button_pipe <= {button_pipe[DEPTH-2:0], button};
		end
	end

	// oldest taps show pressed then released
	assign released = (button_pipe[DEPTH-1:DEPTH-2] == 2'b10);

	// one start pulse per release, chosen by the rotary position
	always_ff @(posedge clock) begin
		if (reset) begin
			start <= '0;
		end else begin
			start <= '0;
			if (released) begin
				case (rot_level)
					4'd1: start[alpha_pkg::SEQ_RESET_BIT] <= 1'b1;
					4'd2: start[alpha_pkg::SEQ_LOAD_BIT]  <= 1'b1;
					4'd3: start[alpha_pkg::SEQ_TOKEN_BIT] <= 1'b1;
					// other positions do nothing
					default: start <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* logic/alpha_bias_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "alpha_cfg.svh"

module alpha_bias_regs (
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic        psel,
	input  wire logic        penable,
	input  wire logic        pwrite,
	input  wire logic [3:0]  paddr,
	input  wire logic [31:0] pwdata,
	output logic [31:0]      prdata,
	output logic             pready,
	output logic             pslverr,
	output logic [11:0]      cmp_bias,
	output logic [11:0]      isel,
	output logic [11:0]      sb_bias,
	output logic [11:0]      db_bias
);

	logic                  wr_en;
	alpha_pkg::bias_addr_t reg_addr;
	logic [11:0]           rd_val;

	// word addressed, paddr[1:0] ignored
	assign reg_addr = alpha_pkg::bias_addr_t'(paddr[3:2]);

	// write lands in the access phase
	assign wr_en = psel && penable && pwrite;

	// no wait states and no error responses
	assign pready  = 1'b1;
	assign pslverr = 1'b0;

	always_ff @(posedge clock) begin
		if (reset) begin
			cmp_bias <= `ALPHA_BIAS_RESET;
			isel     <= `ALPHA_BIAS_RESET;
			sb_bias  <= `ALPHA_BIAS_RESET;
			db_bias  <= `ALPHA_BIAS_RESET;
		end else if (wr_en) begin
			case (reg_addr)
				alpha_pkg::cmp_bias: cmp_bias <= pwdata[11:0];
				alpha_pkg::isel:     isel     <= pwdata[11:0];
				alpha_pkg::sb_bias:  sb_bias  <= pwdata[11:0];
				alpha_pkg::db_bias:  db_bias  <= pwdata[11:0];
				default:             cmp_bias <= cmp_bias;
			endcase
		end
	end

	// read mux
	always_comb begin
		case (reg_addr)
			alpha_pkg::cmp_bias: rd_val = cmp_bias;
			alpha_pkg::isel:     rd_val = isel;
			alpha_pkg::sb_bias:  rd_val = sb_bias;
			alpha_pkg::db_bias:  rd_val = db_bias;
			default:             rd_val = 12'd0;
		endcase
	end

	// upper bits read as zero
	assign prdata = {20'd0, rd_val};

endmodule

`default_nettype wire

/* logic/alpha_pkg.sv */
`default_nettype none

package alpha_pkg;

	// bias register numbering, shared by the APB map and the chip address
	typedef enum logic [1:0] {
		cmp_bias = 2'd0,
		isel     = 2'd1,
		sb_bias  = 2'd2,
		db_bias  = 2'd3
	} bias_addr_t;

	// one serial word for the chip, sent msb first
	typedef struct packed {
		logic [3:0]  addr;
		logic [11:0] value;
	} serial_word_t;

	// chip address of cmp_bias, the others follow in order
	localparam logic [3:0] CHIP_ADDR_BASE = 4'h8;

	// one-hot start vector
	typedef logic [2:0] sequence_t;

	// bit positions inside sequence_t
	localparam int SEQ_RESET_BIT = 0;
	localparam int SEQ_LOAD_BIT  = 1;
	localparam int SEQ_TOKEN_BIT = 2;

endpackage

`default_nettype wire

/* logic/alpha_cfg.svh */
`ifndef ALPHA_CFG_SVH
`define ALPHA_CFG_SVH

// length of the button delay pipeline
`define ALPHA_BUTTON_DEPTH 7

// cycles that dreset is held high in sequence 1
`define ALPHA_DRESET_CYCLES 16

// clock cycles per sclk phase
`define ALPHA_SCLK_HALF 2

// reset value of every bias register
`define ALPHA_BIAS_RESET 12'h844

`endif
